// ==== verilog/agu_params.svh ====
`ifndef AGU_PARAMS_SVH
`define AGU_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath widths

// Data word width
`define AGU_XLEN 32

// Bus address width
`define AGU_ADDR_SIZE 32

// One byte lane per 8 data bits
`define AGU_LANES (`AGU_XLEN / 8)

//////////////////////////////////////////////////
// AMO sequencer

// Seven states fit in three bits
`define AGU_STATE_W 3

`endif

// ==== verilog/agu_pkg.sv ====
`include "agu_params.svh"

package agu_pkg;

  // Data, address and byte mask
  typedef logic [`AGU_XLEN-1:0]      xlen_t;
  typedef logic [`AGU_ADDR_SIZE-1:0] addr_t;
  typedef logic [`AGU_LANES-1:0]     wmask_t;

  // Access size, same code as the bus size field
  typedef enum logic [1:0] {
    SIZE_B = 2'b00,
    SIZE_H = 2'b01,
    SIZE_W = 2'b10
  } size_t;

  // Shared ALU operation
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SWAP = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_MAX  = 4'd5,
    ALU_MIN  = 4'd6,
    ALU_MAXU = 4'd7,
    ALU_MINU = 4'd8
  } amo_op_t;

  // AMO read-modify-write sequence
  typedef enum logic [`AGU_STATE_W-1:0] {
    ST_IDLE    = 3'd0,
    ST_1ST     = 3'd1,
    ST_AMOALU  = 3'd2,
    ST_AMORDY  = 3'd3,
    ST_WAIT2ND = 3'd4,
    ST_2ND     = 3'd5,
    ST_WBCK    = 3'd6
  } amo_state_t;

endpackage

// ==== verilog/agu_alu.sv ====
`timescale 1ns/1ps
`include "agu_params.svh"

module agu_alu import agu_pkg::*; (
  input  xlen_t   op1,
  input  xlen_t   op2,
  input  amo_op_t op,
  output xlen_t   res
);

  // One extra bit so the compare can read the sign of the difference
  logic [`AGU_XLEN:0] add_a;
  logic [`AGU_XLEN:0] add_b;
  logic [`AGU_XLEN:0] add_sum;
  logic               cmp_op;
  logic               signed_cmp;
  logic               op1_lt;

  //////////////////////////////////////////////////
  // Single adder

  // Max and min subtract, everything else adds or bypasses
  assign cmp_op     = (op == ALU_MAX) || (op == ALU_MIN)
                   || (op == ALU_MAXU) || (op == ALU_MINU);
  assign signed_cmp = (op == ALU_MAX) || (op == ALU_MIN);

  // Sign extend for signed compare, zero extend otherwise
  assign add_a = {signed_cmp & op1[`AGU_XLEN-1], op1};
  assign add_b = cmp_op ? ~{signed_cmp & op2[`AGU_XLEN-1], op2} : {1'b0, op2};

  // Carry in completes the two's complement of op2
  assign add_sum = add_a + add_b + {{`AGU_XLEN{1'b0}}, cmp_op};

  // Top bit of the widened difference is set when op1 < op2
  assign op1_lt = add_sum[`AGU_XLEN];

  //////////////////////////////////////////////////
  // Result select

  always_comb begin
    case (op)
      ALU_ADD:  res = add_sum[`AGU_XLEN-1:0];
      ALU_SWAP: res = op2;
      ALU_AND:  res = op1 & op2;
      ALU_OR:   res = op1 | op2;
      ALU_XOR:  res = op1 ^ op2;
      // Signed and unsigned share the same select, only the extension differs
      ALU_MAX,
      ALU_MAXU: res = op1_lt ? op2 : op1;
      ALU_MIN,
      ALU_MINU: res = op1_lt ? op1 : op2;
      default:  res = add_sum[`AGU_XLEN-1:0];
    endcase
  end

  // The AMO operation comes straight from the decoder through the sequencer
  always_comb begin
    assert (op inside {ALU_ADD, ALU_SWAP, ALU_AND, ALU_OR, ALU_XOR,
                       ALU_MAX, ALU_MIN, ALU_MAXU, ALU_MINU})
      else $error("agu_alu: illegal operation code %0d", op);
  end

endmodule

// ==== verilog/agu_amo_seq.sv ====
`timescale 1ns/1ps

module agu_amo_seq import agu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    amo_start,
  input  logic    cmd_ready,
  input  logic    rsp_valid,
  input  logic    rsp_err,
  input  xlen_t   rsp_rdata,
  input  xlen_t   rs1,
  input  xlen_t   rs2,
  input  xlen_t   imm,
  input  xlen_t   alu_res,
  input  logic    is_amo,
  input  logic    o_ready,
  input  amo_op_t amo_op,
  output xlen_t   alu_op1,
  output xlen_t   alu_op2,
  output amo_op_t alu_op,
  output logic    amo_cmd_valid,
  output logic    amo_cmd_read,
  output xlen_t   amo_wdata,
  output xlen_t   amo_old,
  output logic    amo_err,
  output logic    amo_done,
  output logic    amo_busy
);

  amo_state_t state;
  amo_state_t state_nxt;

  // Leftover 0 keeps the old memory word, leftover 1 the ALU result
  xlen_t leftover_0;
  xlen_t leftover_1;
  logic  err_r;

  //////////////////////////////////////////////////
  // Sequencer FSM

  always_comb begin
    state_nxt = state;
    case (state)
      // Leave on the handshake of the locked read
      ST_IDLE:    if (amo_start && cmd_ready) state_nxt = ST_1ST;
      ST_1ST:     if (rsp_valid) state_nxt = ST_AMOALU;
      // ALU is free here, one cycle each
      ST_AMOALU:  state_nxt = ST_AMORDY;
      ST_AMORDY:  state_nxt = ST_WAIT2ND;
      ST_WAIT2ND: if (cmd_ready) state_nxt = ST_2ND;
      ST_2ND:     if (rsp_valid) state_nxt = ST_WBCK;
      // Hold the commit until the write-back side takes it
      ST_WBCK:    if (o_ready) state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Leftover buffers and error bit

  always_ff @(posedge clk) begin
    // Read data of the first access, untouched by the second
    if ((state == ST_1ST) && rsp_valid) begin
      leftover_0 <= rsp_rdata;
    end
    if (state == ST_AMOALU) begin
      leftover_1 <= alu_res;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_r <= 1'b0;
    end else if ((state == ST_1ST) && rsp_valid) begin
      err_r <= rsp_err;
    end else if ((state == ST_2ND) && rsp_valid) begin
      // Second error merged into the first
      err_r <= err_r | rsp_err;
    end
  end

  //////////////////////////////////////////////////
  // ALU operand steering

  always_comb begin
    if (state == ST_AMOALU) begin
      alu_op1 = leftover_0;
      alu_op2 = rs2;
      alu_op  = amo_op;
    end else begin
      // Address add, AMO uses rs1 with no offset
      alu_op1 = rs1;
      alu_op2 = is_amo ? '0 : imm;
      alu_op  = ALU_ADD;
    end
  end

  // Read from idle, write from wait-2nd
  assign amo_cmd_valid = ((state == ST_IDLE) && amo_start) || (state == ST_WAIT2ND);
  assign amo_cmd_read  = (state == ST_IDLE);

  assign amo_wdata = leftover_1;
  assign amo_old   = leftover_0;
  assign amo_err   = err_r;
  assign amo_done  = (state == ST_WBCK);
  assign amo_busy  = (state != ST_IDLE);

  // Only an AMO may start the sequence
  a_idle_needs_amo: assert property (
    @(posedge clk) disable iff (!arst_n)
    ((state == ST_IDLE) && !is_amo) |=> (state == ST_IDLE)
  );

  // Memory answers one command at a time, nothing is pending here
  a_no_rsp_between: assert property (
    @(posedge clk) disable iff (!arst_n)
    (state inside {ST_AMOALU, ST_AMORDY, ST_WAIT2ND}) |-> !rsp_valid
  );

endmodule

// ==== verilog/agu_issue.sv ====
`timescale 1ns/1ps
`include "agu_params.svh"

module agu_issue import agu_pkg::*; (
  input  logic   i_valid,
  input  logic   load,
  input  logic   store,
  input  logic   is_amo,
  input  size_t  size,
  input  xlen_t  rs2,
  input  xlen_t  alu_res,
  input  logic   cmd_ready,
  input  logic   o_ready,
  input  logic   amo_cmd_valid,
  input  logic   amo_cmd_read,
  input  xlen_t  amo_wdata,
  input  xlen_t  amo_old,
  input  logic   amo_err,
  input  logic   amo_done,
  input  logic   amo_busy,
  output logic   amo_start,
  output logic   i_ready,
  output logic   longpipe,
  output logic   agu_o_valid,
  output xlen_t  agu_o_wbck_wdat,
  output logic   agu_o_wbck_err,
  output logic   agu_o_cmt_misalgn,
  output logic   agu_o_cmt_ld,
  output logic   agu_o_cmt_stamo,
  output logic   agu_o_cmt_buserr,
  output addr_t  agu_o_cmt_badaddr,
  output logic   icb_cmd_valid,
  output addr_t  icb_cmd_addr,
  output logic   icb_cmd_read,
  output xlen_t  icb_cmd_wdata,
  output wmask_t icb_cmd_wmask,
  output logic   icb_cmd_lock,
  output size_t  icb_cmd_size
);

  addr_t  addr;
  logic   misalgn;
  logic   misalgn_inst;
  logic   algn_ldst;
  logic   algn_amo;
  xlen_t  st_wdata;
  wmask_t st_wmask;

  //////////////////////////////////////////////////
  // Alignment

  assign addr = alu_res[`AGU_ADDR_SIZE-1:0];

  // A running AMO passed this check in idle
  assign misalgn = !amo_busy
                && (((size == SIZE_H) && addr[0])
                 || ((size == SIZE_W) && (addr[1:0] != 2'b00)));

  assign misalgn_inst = misalgn && (load || store || is_amo);
  assign algn_ldst    = !misalgn && (load || store);
  assign algn_amo     = !misalgn && is_amo;

  // Locked read goes out together with the commit reservation
  assign amo_start = i_valid && algn_amo && !amo_busy && o_ready;

  //////////////////////////////////////////////////
  // Store lane formatting

  always_comb begin
    case (size)
      SIZE_B: begin
        st_wdata = {`AGU_LANES{rs2[7:0]}};
        st_wmask = wmask_t'(1) << addr[1:0];
      end
      SIZE_H: begin
        st_wdata = {(`AGU_LANES / 2){rs2[15:0]}};
        st_wmask = wmask_t'(3) << {addr[1], 1'b0};
      end
      default: begin
        st_wdata = rs2;
        st_wmask = '1;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Bus command

  // Plain loads and stores also need the commit side in the same cycle
  assign icb_cmd_valid = (i_valid && algn_ldst && o_ready) || amo_cmd_valid;
  assign icb_cmd_addr  = addr;
  assign icb_cmd_read  = is_amo ? amo_cmd_read : load;
  assign icb_cmd_wdata = is_amo ? amo_wdata : st_wdata;
  // No write after a failed read
  assign icb_cmd_wmask = is_amo ? (amo_err ? '0 : '1) : st_wmask;
  assign icb_cmd_lock  = algn_amo && !amo_busy;
  assign icb_cmd_size  = size;

  //////////////////////////////////////////////////
  // Issue handshake and commit

  // AMO releases the instruction only when its commit is taken
  assign i_ready  = algn_amo ? (amo_done && o_ready) : (cmd_ready && o_ready);
  assign longpipe = algn_ldst;

  assign agu_o_valid = amo_done || (i_valid && (algn_ldst || misalgn_inst) && cmd_ready);

  assign agu_o_wbck_wdat   = amo_done ? amo_old : '0;
  assign agu_o_cmt_buserr  = amo_done && amo_err;
  assign agu_o_cmt_misalgn = misalgn_inst;
  assign agu_o_cmt_ld      = load;
  assign agu_o_cmt_stamo   = store || is_amo;
  assign agu_o_cmt_badaddr = addr;
  // Exceptions never write the register file
  assign agu_o_wbck_err    = agu_o_cmt_buserr || agu_o_cmt_misalgn;

  // The sequencer's request must never carry a misaligned address
  always_comb begin
    assert (!(icb_cmd_valid && misalgn_inst))
      else $error("agu_issue: bus command for misaligned access");
  end

endmodule

// ==== verilog/agu_top.sv ====
`timescale 1ns/1ps

module agu_top import agu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  // Issue
  input  logic    agu_i_valid,
  output logic    agu_i_ready,
  input  xlen_t   agu_i_rs1,
  input  xlen_t   agu_i_rs2,
  input  xlen_t   agu_i_imm,
  input  logic    agu_i_load,
  input  logic    agu_i_store,
  input  logic    agu_i_amo,
  input  size_t   agu_i_size,
  input  amo_op_t agu_i_amo_op,
  output logic    agu_i_longpipe,
  output logic    amo_wait,
  // Commit and write-back
  output logic    agu_o_valid,
  input  logic    agu_o_ready,
  output xlen_t   agu_o_wbck_wdat,
  output logic    agu_o_wbck_err,
  output logic    agu_o_cmt_misalgn,
  output logic    agu_o_cmt_ld,
  output logic    agu_o_cmt_stamo,
  output logic    agu_o_cmt_buserr,
  output addr_t   agu_o_cmt_badaddr,
  // Bus command
  output logic    icb_cmd_valid,
  input  logic    icb_cmd_ready,
  output addr_t   icb_cmd_addr,
  output logic    icb_cmd_read,
  output xlen_t   icb_cmd_wdata,
  output wmask_t  icb_cmd_wmask,
  output logic    icb_cmd_lock,
  output size_t   icb_cmd_size,
  // Bus response, always accepted
  input  logic    icb_rsp_valid,
  input  logic    icb_rsp_err,
  input  xlen_t   icb_rsp_rdata
);

  xlen_t   alu_op1;
  xlen_t   alu_op2;
  amo_op_t alu_op;
  xlen_t   alu_res;
  logic    amo_start;
  logic    amo_cmd_valid;
  logic    amo_cmd_read;
  xlen_t   amo_wdata;
  xlen_t   amo_old;
  logic    amo_err;
  logic    amo_done;

  agu_alu i_agu_alu (
    .op1 (alu_op1),
    .op2 (alu_op2),
    .op  (alu_op),
    .res (alu_res)
  );

  // Busy flag is the pipeline's AMO wait
  agu_amo_seq i_agu_amo_seq (
    .clk           (clk),
    .arst_n        (arst_n),
    .amo_start     (amo_start),
    .cmd_ready     (icb_cmd_ready),
    .rsp_valid     (icb_rsp_valid),
    .rsp_err       (icb_rsp_err),
    .rsp_rdata     (icb_rsp_rdata),
    .rs1           (agu_i_rs1),
    .rs2           (agu_i_rs2),
    .imm           (agu_i_imm),
    .alu_res       (alu_res),
    .is_amo        (agu_i_amo),
    .o_ready       (agu_o_ready),
    .amo_op        (agu_i_amo_op),
    .alu_op1       (alu_op1),
    .alu_op2       (alu_op2),
    .alu_op        (alu_op),
    .amo_cmd_valid (amo_cmd_valid),
    .amo_cmd_read  (amo_cmd_read),
    .amo_wdata     (amo_wdata),
    .amo_old       (amo_old),
    .amo_err       (amo_err),
    .amo_done      (amo_done),
    .amo_busy      (amo_wait)
  );

  agu_issue i_agu_issue (
    .i_valid           (agu_i_valid),
    .load              (agu_i_load),
    .store             (agu_i_store),
    .is_amo            (agu_i_amo),
    .size              (agu_i_size),
    .rs2               (agu_i_rs2),
    .alu_res           (alu_res),
    .cmd_ready         (icb_cmd_ready),
    .o_ready           (agu_o_ready),
    .amo_cmd_valid     (amo_cmd_valid),
    .amo_cmd_read      (amo_cmd_read),
    .amo_wdata         (amo_wdata),
    .amo_old           (amo_old),
    .amo_err           (amo_err),
    .amo_done          (amo_done),
    .amo_busy          (amo_wait),
    .amo_start         (amo_start),
    .i_ready           (agu_i_ready),
    .longpipe          (agu_i_longpipe),
    .agu_o_valid       (agu_o_valid),
    .agu_o_wbck_wdat   (agu_o_wbck_wdat),
    .agu_o_wbck_err    (agu_o_wbck_err),
    .agu_o_cmt_misalgn (agu_o_cmt_misalgn),
    .agu_o_cmt_ld      (agu_o_cmt_ld),
    .agu_o_cmt_stamo   (agu_o_cmt_stamo),
    .agu_o_cmt_buserr  (agu_o_cmt_buserr),
    .agu_o_cmt_badaddr (agu_o_cmt_badaddr),
    .icb_cmd_valid     (icb_cmd_valid),
    .icb_cmd_addr      (icb_cmd_addr),
    .icb_cmd_read      (icb_cmd_read),
    .icb_cmd_wdata     (icb_cmd_wdata),
    .icb_cmd_wmask     (icb_cmd_wmask),
    .icb_cmd_lock      (icb_cmd_lock),
    .icb_cmd_size      (icb_cmd_size)
  );

endmodule

// ==== testbench/agu_ref_model.svh ====
`ifndef AGU_REF_MODEL_SVH
`define AGU_REF_MODEL_SVH

//////////////////////////////////////////////////
// Word memory behind the bus

// 16 words cover byte addresses 0 to 63
localparam int MEM_WORDS = 16;

xlen_t mem [MEM_WORDS];

// Each word's start value is derived from its own address
function automatic void fill_memory();
  for (int i = 0; i < MEM_WORDS; i++) begin
    mem[i] = (xlen_t'(i * 4) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  end
endfunction

// Byte enables pick which lanes change
function automatic void write_memory(addr_t addr, xlen_t data, wmask_t mask);
  for (int b = 0; b < 4; b++) begin
    if (mask[b]) begin
      mem[addr[5:2]][8*b +: 8] = data[8*b +: 8];
    end
  end
endfunction

//////////////////////////////////////////////////
// Expected values of the unit

// AMO addresses with rs1 alone, loads and stores add the immediate
function automatic addr_t expect_addr(logic amo, xlen_t rs1, xlen_t imm);
  return amo ? rs1 : rs1 + imm;
endfunction

function automatic int size_bytes(size_t size);
  case (size)
    SIZE_B:  return 1;
    SIZE_H:  return 2;
    default: return 4;
  endcase
endfunction

// Natural alignment, address a multiple of the access size
function automatic logic is_misaligned(size_t size, addr_t addr);
  return (int'(addr[1:0]) % size_bytes(size)) != 0;
endfunction

// Each lane carries the store byte that falls in it after the shift
function automatic xlen_t store_data(size_t size, xlen_t rs2);
  xlen_t data;
  int    n;
  n = size_bytes(size);
  for (int b = 0; b < 4; b++) begin
    data[8*b +: 8] = rs2[8*(b % n) +: 8];
  end
  return data;
endfunction

// Lanes from the low address bits up to the access size
function automatic wmask_t store_mask(size_t size, addr_t addr);
  wmask_t mask;
  int     lo;
  int     n;
  lo = int'(addr[1:0]);
  n  = size_bytes(size);
  for (int b = 0; b < 4; b++) begin
    mask[b] = (b >= lo) && (b < lo + n);
  end
  return mask;
endfunction

// RISC-V AMO semantics, old memory word against rs2
function automatic xlen_t amo_result(amo_op_t op, xlen_t old, xlen_t rs2);
  case (op)
    ALU_ADD:  return old + rs2;
    ALU_SWAP: return rs2;
    ALU_AND:  return old & rs2;
    ALU_OR:   return old | rs2;
    ALU_MAX:  return ($signed(old) > $signed(rs2)) ? old : rs2;
    ALU_MIN:  return ($signed(old) < $signed(rs2)) ? old : rs2;
    ALU_MAXU: return (old > rs2) ? old : rs2;
    ALU_MINU: return (old < rs2) ? old : rs2;
    default:  return old ^ rs2;
  endcase
endfunction

`endif

// ==== testbench/tb_agu.sv ====
`timescale 1ns/1ps

module tb_agu import agu_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int N_INSTR    = 400;
  // Worst AMO: two handshakes, two delayed responses and stalled commit
  localparam int CYCLES_PER_INSTR = 60;
  localparam int TIMEOUT_CYCLES   = N_INSTR * CYCLES_PER_INSTR;

  logic clk, arst_n;
  logic agu_i_valid, agu_i_ready, agu_i_load, agu_i_store, agu_i_amo;
  xlen_t agu_i_rs1, agu_i_rs2, agu_i_imm;
  size_t agu_i_size;
  amo_op_t agu_i_amo_op;
  logic agu_i_longpipe, amo_wait;
  logic agu_o_valid, agu_o_ready, agu_o_wbck_err, agu_o_cmt_misalgn;
  logic agu_o_cmt_ld, agu_o_cmt_stamo, agu_o_cmt_buserr;
  xlen_t agu_o_wbck_wdat;
  addr_t agu_o_cmt_badaddr;
  logic icb_cmd_valid, icb_cmd_ready, icb_cmd_read, icb_cmd_lock;
  addr_t icb_cmd_addr;
  xlen_t icb_cmd_wdata;
  wmask_t icb_cmd_wmask;
  size_t icb_cmd_size;
  logic icb_rsp_valid, icb_rsp_err;
  xlen_t icb_rsp_rdata;

  // Scoreboard of the instruction on the issue port
  logic  inst_live, exp_misalgn, amo_active, amo_err_rd, amo_err_wr;
  int    inst_num, n_commits, cmd_seen, cmd_expected, cycle_count;
  addr_t exp_addr;
  xlen_t amo_old_exp;

  // Pending bus response
  logic  rsp_pending, rsp_err_q;
  int    rsp_delay;
  xlen_t rsp_data;

  `include "agu_ref_model.svh"

  agu_top i_agu_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compares

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_mask(input string name, input wmask_t expected, input wmask_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_size(input string name, input size_t expected, input size_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s expected %b actual %b", name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  task automatic present_instruction();
    int kind;
    kind         = $urandom % 3;
    agu_i_load   = (kind == 0);
    agu_i_store  = (kind == 1);
    agu_i_amo    = (kind == 2);
    agu_i_rs2    = $urandom;
    agu_i_amo_op = amo_op_t'($urandom % 9);
    agu_i_imm    = xlen_t'($urandom % 16) - 32'd8;
    if (agu_i_amo) begin
      // Word AMO, one in four lands off a word boundary
      agu_i_size = SIZE_W;
      agu_i_rs1  = xlen_t'(($urandom % 16) * 4);
      if (($urandom % 4) == 0) begin
        agu_i_rs1 = agu_i_rs1 + 1 + ($urandom % 3);
      end
    end else begin
      agu_i_size = size_t'($urandom % 3);
      agu_i_rs1  = xlen_t'(8 + ($urandom % 48));
    end
    exp_addr     = expect_addr(agu_i_amo, agu_i_rs1, agu_i_imm);
    exp_misalgn  = is_misaligned(agu_i_size, exp_addr);
    cmd_expected = exp_misalgn ? 0 : (agu_i_amo ? 2 : 1);
    cmd_seen     = 0;
    amo_err_rd   = 1'b0;
    amo_err_wr   = 1'b0;
    agu_i_valid  = 1'b1;
    inst_live    = 1'b1;
    inst_num++;
  endtask

  // Falling edge, random stalls, one response, maybe a new instruction
  task automatic drive_inputs();
    agu_o_ready   = ($urandom % 4) != 0;
    icb_cmd_ready = ($urandom % 4) != 0;
    if (rsp_pending && (rsp_delay == 0)) begin
      icb_rsp_valid = 1'b1;
      icb_rsp_err   = rsp_err_q;
      icb_rsp_rdata = rsp_data;
      rsp_pending   = 1'b0;
    end else begin
      icb_rsp_valid = 1'b0;
      icb_rsp_err   = 1'b0;
      if (rsp_pending) begin
        rsp_delay--;
      end
    end
    // A new instruction waits for the previous response
    if (!inst_live) begin
      agu_i_valid = 1'b0;
      if (!rsp_pending && (inst_num < N_INSTR) && (($urandom % 4) != 0)) begin
        present_instruction();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Scoring

  task automatic score_command();
    string tag;
    tag = $sformatf("instr %0d cmd %0d", inst_num, cmd_seen);
    if (!inst_live || (cmd_seen >= cmd_expected)) begin
      fail_run($sformatf("Bus command accepted that instruction %0d should not issue", inst_num));
    end
    check_addr({tag, " addr"}, exp_addr, icb_cmd_addr);
    check_size({tag, " size"}, agu_i_size, icb_cmd_size);
    if (agu_i_amo) begin
      // Locked read first, then the plain write
      check_bit({tag, " read"}, cmd_seen == 0, icb_cmd_read);
      check_bit({tag, " lock"}, cmd_seen == 0, icb_cmd_lock);
      if (cmd_seen == 1) begin
        check_word({tag, " wdata"}, amo_result(agu_i_amo_op, amo_old_exp, agu_i_rs2),
                   icb_cmd_wdata);
        check_mask({tag, " wmask"}, amo_err_rd ? 4'h0 : 4'hf, icb_cmd_wmask);
      end
    end else begin
      check_bit({tag, " read"}, agu_i_load, icb_cmd_read);
      check_bit({tag, " lock"}, 1'b0, icb_cmd_lock);
      if (agu_i_store) begin
        check_word({tag, " wdata"}, store_data(agu_i_size, agu_i_rs2), icb_cmd_wdata);
        check_mask({tag, " wmask"}, store_mask(agu_i_size, exp_addr), icb_cmd_wmask);
      end
    end
    // Memory answers after a random delay, sometimes with an error
    rsp_pending = 1'b1;
    rsp_delay   = $urandom % 3;
    rsp_err_q   = ($urandom % 6) == 0;
    rsp_data    = mem[icb_cmd_addr[5:2]];
    if (!icb_cmd_read) begin
      write_memory(icb_cmd_addr, icb_cmd_wdata, icb_cmd_wmask);
    end
    if (agu_i_amo && (cmd_seen == 0)) begin
      amo_old_exp = rsp_data;
      amo_err_rd  = rsp_err_q;
      amo_active  = 1'b1;
    end else if (agu_i_amo) begin
      amo_err_wr = rsp_err_q;
    end
    cmd_seen++;
  endtask

  task automatic score_commit();
    string tag;
    logic  buserr;
    tag    = $sformatf("instr %0d commit", inst_num);
    buserr = agu_i_amo && !exp_misalgn && (amo_err_rd || amo_err_wr);
    if (!inst_live) begin
      fail_run("Commit seen with no instruction on the issue port");
    end
    if (cmd_seen != cmd_expected) begin
      fail_run($sformatf("Instruction %0d committed after %0d of %0d bus commands",
                         inst_num, cmd_seen, cmd_expected));
    end
    check_bit({tag, " issue ready"}, 1'b1, agu_i_ready);
    // Only a load or store that reaches the bus goes down the long pipe
    check_bit({tag, " longpipe"}, (agu_i_load || agu_i_store) && !exp_misalgn,
              agu_i_longpipe);
    check_bit({tag, " misalgn"}, exp_misalgn, agu_o_cmt_misalgn);
    check_bit({tag, " buserr"}, buserr, agu_o_cmt_buserr);
    check_bit({tag, " wbck_err"}, exp_misalgn || buserr, agu_o_wbck_err);
    check_bit({tag, " ld"}, agu_i_load, agu_o_cmt_ld);
    check_bit({tag, " stamo"}, agu_i_store || agu_i_amo, agu_o_cmt_stamo);
    check_addr({tag, " badaddr"}, exp_addr, agu_o_cmt_badaddr);
    if (agu_i_amo && !exp_misalgn) begin
      check_word({tag, " wbck data"}, amo_old_exp, agu_o_wbck_wdat);
      // Failed read leaves the word untouched
      check_word({tag, " memory"},
                 amo_err_rd ? amo_old_exp : amo_result(agu_i_amo_op, amo_old_exp, agu_i_rs2),
                 mem[exp_addr[5:2]]);
    end
    amo_active = 1'b0;
    inst_live  = 1'b0;
    n_commits++;
  endtask

  // Mid low phase, inputs and state both settled
  task automatic sample_outputs();
    check_bit($sformatf("instr %0d amo_wait", inst_num), amo_active, amo_wait);
    if (!inst_live) begin
      check_bit("idle cmd valid", 1'b0, icb_cmd_valid);
      check_bit("idle commit valid", 1'b0, agu_o_valid);
    end else if (exp_misalgn) begin
      check_bit($sformatf("instr %0d misaligned cmd valid", inst_num), 1'b0, icb_cmd_valid);
    end
    if (icb_cmd_valid && icb_cmd_ready) begin
      score_command();
    end
    if (agu_o_valid && agu_o_ready) begin
      score_commit();
    end else if (agu_i_valid && agu_i_ready) begin
      fail_run($sformatf("Instruction %0d left the issue port without a commit", inst_num));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(27909));
    fill_memory();
    arst_n        = 1'b0;
    agu_i_valid   = 1'b0;
    agu_i_rs1     = '0;
    agu_i_rs2     = '0;
    agu_i_imm     = '0;
    agu_i_load    = 1'b0;
    agu_i_store   = 1'b0;
    agu_i_amo     = 1'b0;
    agu_i_size    = SIZE_B;
    agu_i_amo_op  = ALU_ADD;
    agu_o_ready   = 1'b0;
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp_err   = 1'b0;
    icb_rsp_rdata = '0;
    inst_live     = 1'b0;
    exp_misalgn   = 1'b0;
    amo_active    = 1'b0;
    rsp_pending   = 1'b0;
    inst_num      = 0;
    n_commits     = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while ((n_commits < N_INSTR) || rsp_pending) begin
      drive_inputs();
      #(CLK_PERIOD / 4);
      sample_outputs();
      @(negedge clk);
    end
    $display("Verification passed");
    $finish;
  end

  // Hang guard
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    fail_run($sformatf("Timeout after %0d cycles with %0d of %0d instructions committed",
                       cycle_count, n_commits, N_INSTR));
  end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+testbench
verilog/agu_pkg.sv
verilog/agu_alu.sv
verilog/agu_amo_seq.sv
verilog/agu_issue.sv
verilog/agu_top.sv
testbench/tb_agu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AGU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
  --top-module tb_agu \
  -Mdir "$BUILD_DIR" -o tb_agu_sim \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_agu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "ERROR: simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
fi
echo "RESULT: FAIL"
exit 1
